// File: design/issue_arbiter.sv
/* Round-robin choice between the ALU and multiplier bank requests.
   Drives the single issue port and returns a one-cycle grant to the winner. */
module issue_arbiter (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           alu_req,
    input  rs_pkg::alu_op_t                alu_op,
    input  logic [rs_pkg::TAG_WIDTH-1:0]   alu_tag,
    input  logic [rs_pkg::DATA_WIDTH-1:0]  alu_a,
    input  logic [rs_pkg::DATA_WIDTH-1:0]  alu_b,
    input  logic                           mult_req,
    input  rs_pkg::mult_op_t               mult_op,
    input  logic [rs_pkg::TAG_WIDTH-1:0]   mult_tag,
    input  logic [rs_pkg::DATA_WIDTH-1:0]  mult_a,
    input  logic [rs_pkg::DATA_WIDTH-1:0]  mult_b,
    output logic                           alu_grant,
    output logic                           mult_grant,
    output logic                           issue_valid,
    output rs_pkg::fu_t                    issue_fu,
    output rs_pkg::alu_op_t                issue_alu_op,
    output rs_pkg::mult_op_t               issue_mult_op,
    output logic [rs_pkg::TAG_WIDTH-1:0]   issue_dest_tag,
    output logic [rs_pkg::DATA_WIDTH-1:0]  issue_a,
    output logic [rs_pkg::DATA_WIDTH-1:0]  issue_b
);

    logic mult_prio;  // High when multiplier wins a tie
    logic contested;

    assign contested = alu_req && mult_req;

    // Grant the lone requester, else the one holding priority
    assign alu_grant  = alu_req && (!mult_req || !mult_prio);
    assign mult_grant = mult_req && !alu_grant;

    // Priority moves to the loser only after a tie
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mult_prio <= 1'b0;  // ALU first
        end else if (contested) begin
            mult_prio <= !mult_prio;
        end
    end

    assign issue_valid = alu_req || mult_req;
    assign issue_fu    = mult_grant ? rs_pkg::FU_MULT : rs_pkg::FU_ALU;

    // Unselected op field rests at its first encoding
    assign issue_alu_op  = alu_grant ? alu_op : rs_pkg::ADD;
    assign issue_mult_op = mult_grant ? mult_op : rs_pkg::MUL_LO;

    assign issue_dest_tag = mult_grant ? mult_tag : alu_tag;
    assign issue_a        = mult_grant ? mult_a : alu_a;
    assign issue_b        = mult_grant ? mult_b : alu_b;

endmodule

// File: design/rs_bank.sv
/* Reservation-station bank: holds dispatched ops until both operands are
   known, wakes them from the CDB and offers the lowest ready entry for issue. */
module rs_bank #(
    parameter int  DEPTH     = 2,
    parameter type payload_t = logic
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           squash,
    input  logic                           alloc,
    input  payload_t                       alloc_op,
    input  logic [rs_pkg::TAG_WIDTH-1:0]   dest_tag,
    input  logic [rs_pkg::TAG_WIDTH-1:0]   a_tag,
    input  logic [rs_pkg::TAG_WIDTH-1:0]   b_tag,
    input  logic                           a_ready,
    input  logic                           b_ready,
    input  logic [rs_pkg::DATA_WIDTH-1:0]  a_value,
    input  logic [rs_pkg::DATA_WIDTH-1:0]  b_value,
    input  logic                           cdb_valid,
    input  logic [rs_pkg::TAG_WIDTH-1:0]   cdb_tag,
    input  logic [rs_pkg::DATA_WIDTH-1:0]  cdb_value,
    input  logic                           grant,
    output logic                           free_avail,
    output logic                           req,
    output payload_t                       req_op,
    output logic [rs_pkg::TAG_WIDTH-1:0]   req_tag,
    output logic [rs_pkg::DATA_WIDTH-1:0]  req_a,
    output logic [rs_pkg::DATA_WIDTH-1:0]  req_b
);

    // Control state per entry
    logic [DEPTH-1:0] busy;
    logic [DEPTH-1:0] a_rdy;
    logic [DEPTH-1:0] b_rdy;

    // Payload per entry
    payload_t                          op_q    [DEPTH];
    logic [rs_pkg::TAG_WIDTH-1:0]      dest_q  [DEPTH];
    logic [rs_pkg::TAG_WIDTH-1:0]      a_tag_q [DEPTH];
    logic [rs_pkg::TAG_WIDTH-1:0]      b_tag_q [DEPTH];
    logic [rs_pkg::DATA_WIDTH-1:0]     a_val_q [DEPTH];
    logic [rs_pkg::DATA_WIDTH-1:0]     b_val_q [DEPTH];

    logic [DEPTH-1:0] alloc_sel;   // One-hot, lowest free entry
    logic [DEPTH-1:0] ready_vec;   // Busy with both operands in
    logic [DEPTH-1:0] issue_sel;   // One-hot, lowest ready entry
    logic [DEPTH-1:0] a_wake;      // CDB match on waiting source a
    logic [DEPTH-1:0] b_wake;
    logic             alloc_fire;
    logic             any_ready;

    // Same-cycle bypass from the CDB at dispatch
    logic a_bypass;
    logic b_bypass;

    assign a_bypass = cdb_valid && (cdb_tag == a_tag);
    assign b_bypass = cdb_valid && (cdb_tag == b_tag);

    assign free_avail = ~&busy;
    assign alloc_fire = alloc && !squash;  // Squash edge drops dispatch

    // Lowest free slot, none selected when full
    always_comb begin
        logic found;
        found     = 1'b0;
        alloc_sel = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!found && !busy[i]) begin
                found        = 1'b1;
                alloc_sel[i] = 1'b1;
            end
        end
    end

    // Wakeup compare, only on sources still waiting
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            a_wake[i] = busy[i] && !a_rdy[i] && cdb_valid && (cdb_tag == a_tag_q[i]);
            b_wake[i] = busy[i] && !b_rdy[i] && cdb_valid && (cdb_tag == b_tag_q[i]);
        end
    end

    assign ready_vec = busy & a_rdy & b_rdy;

    // Priority pick of the request, lowest index wins
    always_comb begin
        any_ready = 1'b0;
        issue_sel = '0;
        req_op    = op_q[0];
        req_tag   = dest_q[0];
        req_a     = a_val_q[0];
        req_b     = b_val_q[0];
        for (int i = 0; i < DEPTH; i++) begin
            if (!any_ready && ready_vec[i]) begin
                any_ready    = 1'b1;
                issue_sel[i] = 1'b1;
                req_op       = op_q[i];
                req_tag      = dest_q[i];
                req_a        = a_val_q[i];
                req_b        = b_val_q[i];
            end
        end
    end

    assign req = any_ready && !squash;  // Held off during squash

    // Busy and operand-ready bits
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy  <= '0;
            a_rdy <= '0;
            b_rdy <= '0;
        end else if (squash) begin
            busy <= '0;  // Flush all entries
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (grant && issue_sel[i]) begin
                    busy[i] <= 1'b0;  // Issued, slot free next cycle
                end
                if (alloc_fire && alloc_sel[i]) begin
                    busy[i]  <= 1'b1;
                    a_rdy[i] <= a_ready || a_bypass;
                    b_rdy[i] <= b_ready || b_bypass;
                end
                if (a_wake[i]) begin
                    a_rdy[i] <= 1'b1;
                end
                if (b_wake[i]) begin
                    b_rdy[i] <= 1'b1;
                end
            end
        end
    end

    // Entry payload, written on allocate and on CDB capture
    always_ff @(posedge clock) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (alloc_fire && alloc_sel[i]) begin
                op_q[i]    <= alloc_op;
                dest_q[i]  <= dest_tag;
                a_tag_q[i] <= a_tag;
                b_tag_q[i] <= b_tag;
                a_val_q[i] <= a_ready ? a_value : cdb_value;  // Bypass value if waiting
                b_val_q[i] <= b_ready ? b_value : cdb_value;
            end
            if (a_wake[i]) begin
                a_val_q[i] <= cdb_value;
            end
            if (b_wake[i]) begin
                b_val_q[i] <= cdb_value;
            end
        end
    end

endmodule

// File: design/rs_cluster.sv
/* Issue cluster top: steers dispatch to the ALU or multiplier bank, feeds
   both from the CDB and merges their requests into one issue port. */
module rs_cluster (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           squash,
    // Dispatch strobe and payload
    input  logic                           dispatch_valid,
    input  rs_pkg::fu_t                    dispatch_fu,
    input  rs_pkg::alu_op_t                dispatch_alu_op,
    input  rs_pkg::mult_op_t               dispatch_mult_op,
    input  logic [rs_pkg::TAG_WIDTH-1:0]   dispatch_dest_tag,
    input  logic [rs_pkg::TAG_WIDTH-1:0]   src_a_tag,
    input  logic                           src_a_ready,
    input  logic [rs_pkg::DATA_WIDTH-1:0]  src_a_value,
    input  logic [rs_pkg::TAG_WIDTH-1:0]   src_b_tag,
    input  logic                           src_b_ready,
    input  logic [rs_pkg::DATA_WIDTH-1:0]  src_b_value,
    // Common data bus
    input  logic                           cdb_valid,
    input  logic [rs_pkg::TAG_WIDTH-1:0]   cdb_tag,
    input  logic [rs_pkg::DATA_WIDTH-1:0]  cdb_value,
    // Bank space
    output logic                           alu_ready,
    output logic                           mult_ready,
    // Issue port
    output logic                           issue_valid,
    output rs_pkg::fu_t                    issue_fu,
    output rs_pkg::alu_op_t                issue_alu_op,
    output rs_pkg::mult_op_t               issue_mult_op,
    output logic [rs_pkg::TAG_WIDTH-1:0]   issue_dest_tag,
    output logic [rs_pkg::DATA_WIDTH-1:0]  issue_a,
    output logic [rs_pkg::DATA_WIDTH-1:0]  issue_b
);

    logic alu_alloc;
    logic mult_alloc;

    // Bank to arbiter
    logic                          alu_req;
    rs_pkg::alu_op_t               alu_req_op;
    logic [rs_pkg::TAG_WIDTH-1:0]  alu_req_tag;
    logic [rs_pkg::DATA_WIDTH-1:0] alu_req_a;
    logic [rs_pkg::DATA_WIDTH-1:0] alu_req_b;
    logic                          mult_req;
    rs_pkg::mult_op_t              mult_req_op;
    logic [rs_pkg::TAG_WIDTH-1:0]  mult_req_tag;
    logic [rs_pkg::DATA_WIDTH-1:0] mult_req_a;
    logic [rs_pkg::DATA_WIDTH-1:0] mult_req_b;
    logic                          alu_grant;
    logic                          mult_grant;

    // Unit decode of the dispatch strobe
    assign alu_alloc  = dispatch_valid && (dispatch_fu == rs_pkg::FU_ALU);
    assign mult_alloc = dispatch_valid && (dispatch_fu == rs_pkg::FU_MULT);

    rs_bank #(
        .DEPTH     (rs_pkg::ALU_ENTRIES),
        .payload_t (rs_pkg::alu_op_t)
    ) alu_bank (
        .clock, .reset, .squash,
        .alloc      (alu_alloc),
        .alloc_op   (dispatch_alu_op),
        .dest_tag   (dispatch_dest_tag),
        .a_tag      (src_a_tag),
        .b_tag      (src_b_tag),
        .a_ready    (src_a_ready),
        .b_ready    (src_b_ready),
        .a_value    (src_a_value),
        .b_value    (src_b_value),
        .cdb_valid, .cdb_tag, .cdb_value,
        .grant      (alu_grant),
        .free_avail (alu_ready),
        .req        (alu_req),
        .req_op     (alu_req_op),
        .req_tag    (alu_req_tag),
        .req_a      (alu_req_a),
        .req_b      (alu_req_b)
    );

    rs_bank #(
        .DEPTH     (rs_pkg::MULT_ENTRIES),
        .payload_t (rs_pkg::mult_op_t)
    ) mult_bank (
        .clock, .reset, .squash,
        .alloc      (mult_alloc),
        .alloc_op   (dispatch_mult_op),
        .dest_tag   (dispatch_dest_tag),
        .a_tag      (src_a_tag),
        .b_tag      (src_b_tag),
        .a_ready    (src_a_ready),
        .b_ready    (src_b_ready),
        .a_value    (src_a_value),
        .b_value    (src_b_value),
        .cdb_valid, .cdb_tag, .cdb_value,
        .grant      (mult_grant),
        .free_avail (mult_ready),
        .req        (mult_req),
        .req_op     (mult_req_op),
        .req_tag    (mult_req_tag),
        .req_a      (mult_req_a),
        .req_b      (mult_req_b)
    );

    issue_arbiter arbiter (
        .clock, .reset,
        .alu_req    (alu_req),
        .alu_op     (alu_req_op),
        .alu_tag    (alu_req_tag),
        .alu_a      (alu_req_a),
        .alu_b      (alu_req_b),
        .mult_req   (mult_req),
        .mult_op    (mult_req_op),
        .mult_tag   (mult_req_tag),
        .mult_a     (mult_req_a),
        .mult_b     (mult_req_b),
        .alu_grant  (alu_grant),
        .mult_grant (mult_grant),
        .issue_valid, .issue_fu, .issue_alu_op, .issue_mult_op,
        .issue_dest_tag, .issue_a, .issue_b
    );

endmodule

// File: design/rs_pkg.sv
/* Shared widths, bank depths and opcode enums for the issue cluster.
   Referenced by scoped name from the RTL and the testbench. */
package rs_pkg;

    // Producer tag, names a reorder-buffer slot
    localparam int TAG_WIDTH = 4;

    // Operand width
    localparam int DATA_WIDTH = 32;

    // Bank depths
    localparam int ALU_ENTRIES  = 3;
    localparam int MULT_ENTRIES = 2;

    // Unit selector
    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_t;

    // ALU operations
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4
    } alu_op_t;

    // Multiplier operations, low or high half of product
    typedef enum logic {
        MUL_LO = 1'b0,
        MUL_HI = 1'b1
    } mult_op_t;

endpackage

// File: project.f
design/rs_pkg.sv
design/rs_bank.sv
design/issue_arbiter.sv
design/rs_cluster.sv
sim/rs_cluster_props.sv
sim/rs_cluster_tb.sv

// File: sim/rs_cluster_props.sv
/* Bound checker for the issue cluster. A per-tag model of dispatched ops and
   their waiting sources backs the concurrent assertions. */
module rs_cluster_props (
    input logic                           clock, reset, squash,
    input logic                           dispatch_valid, src_a_ready, src_b_ready,
    input rs_pkg::fu_t                    dispatch_fu, issue_fu,
    input rs_pkg::alu_op_t                dispatch_alu_op, issue_alu_op,
    input rs_pkg::mult_op_t               dispatch_mult_op, issue_mult_op,
    input logic [rs_pkg::TAG_WIDTH-1:0]   dispatch_dest_tag, src_a_tag, src_b_tag,
    input logic                           cdb_valid,
    input logic [rs_pkg::TAG_WIDTH-1:0]   cdb_tag, issue_dest_tag,
    input logic                           alu_ready, mult_ready, alu_req, mult_req,
    input logic                           issue_valid,
    input logic [rs_pkg::DATA_WIDTH-1:0]  issue_a, issue_b
);

    localparam int NTAGS = 1 << rs_pkg::TAG_WIDTH;

    logic [NTAGS-1:0]              live;    // Dispatched and not yet issued or squashed
    logic [NTAGS-1:0]              a_wait;  // Source still owed a broadcast
    logic [NTAGS-1:0]              b_wait;
    rs_pkg::fu_t                   fu_q  [NTAGS];
    logic [2:0]                    op_q  [NTAGS];
    logic [rs_pkg::TAG_WIDTH-1:0]  a_src [NTAGS];
    logic [rs_pkg::TAG_WIDTH-1:0]  b_src [NTAGS];
    logic                          seen_dispatch;
    logic                          accept;    // Dispatch the banks really take
    logic [2:0]                    issue_op;  // Op of the granted unit
    int                            alu_count;
    int                            mult_count;
    int                            error_count = 0;

    // Operand value is tag times 16#1111
    function automatic logic [rs_pkg::DATA_WIDTH-1:0] tag_value(
        input logic [rs_pkg::TAG_WIDTH-1:0] t);
        logic [rs_pkg::DATA_WIDTH-1:0] v;
        v = t;
        return v * 16'h1111;
    endfunction

    // Tally and raise one failed check
    function automatic void log_failure(input string msg);
        error_count++;
        $error("%s", msg);
    endfunction

    assign accept = dispatch_valid && !squash &&
                    ((dispatch_fu == rs_pkg::FU_ALU) ? alu_count < rs_pkg::ALU_ENTRIES
                                                     : mult_count < rs_pkg::MULT_ENTRIES);
    assign issue_op = (issue_fu == rs_pkg::FU_ALU) ? issue_alu_op : {2'b00, issue_mult_op};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            live          <= '0;
            a_wait        <= '0;
            b_wait        <= '0;
            seen_dispatch <= 1'b0;
        end else begin
            if (dispatch_valid) begin
                seen_dispatch <= 1'b1;
            end
            if (squash) begin
                live <= '0;  // Flush drops every held tag
            end else begin
                for (int t = 0; t < NTAGS; t++) begin
                    if (cdb_valid && cdb_tag == a_src[t]) begin
                        a_wait[t] <= 1'b0;
                    end
                    if (cdb_valid && cdb_tag == b_src[t]) begin
                        b_wait[t] <= 1'b0;
                    end
                end
                if (issue_valid) begin
                    live[issue_dest_tag] <= 1'b0;
                end
                if (accept) begin
                    live[dispatch_dest_tag]  <= 1'b1;
                    fu_q[dispatch_dest_tag]  <= dispatch_fu;
                    op_q[dispatch_dest_tag]  <= (dispatch_fu == rs_pkg::FU_ALU) ?
                                                dispatch_alu_op : {2'b00, dispatch_mult_op};
                    a_src[dispatch_dest_tag] <= src_a_tag;
                    b_src[dispatch_dest_tag] <= src_b_tag;
                    // Bypass counts as arrived
                    a_wait[dispatch_dest_tag] <= !src_a_ready &&
                                                 !(cdb_valid && cdb_tag == src_a_tag);
                    b_wait[dispatch_dest_tag] <= !src_b_ready &&
                                                 !(cdb_valid && cdb_tag == src_b_tag);
                end
            end
        end
    end

    // Held entries per bank
    always_comb begin
        alu_count  = 0;
        mult_count = 0;
        for (int t = 0; t < NTAGS; t++) begin
            alu_count  += int'(live[t] && fu_q[t] == rs_pkg::FU_ALU);
            mult_count += int'(live[t] && fu_q[t] == rs_pkg::FU_MULT);
        end
    end

    a_idle: assert property (@(posedge clock) disable iff (reset)
        !seen_dispatch |-> !issue_valid && alu_ready && mult_ready)
        else log_failure("cluster not idle between reset and the first dispatch");

    a_live: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> live[issue_dest_tag] && fu_q[issue_dest_tag] == issue_fu &&
                        op_q[issue_dest_tag] == issue_op &&
                        ((issue_fu == rs_pkg::FU_ALU) ? issue_mult_op == rs_pkg::MUL_LO
                                                      : issue_alu_op == rs_pkg::ADD))
        else log_failure($sformatf("error at %0t: tag %0d not held with this unit and op",
                                   $time, $sampled(issue_dest_tag)));

    a_wake: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> !a_wait[issue_dest_tag] && !b_wait[issue_dest_tag])
        else log_failure("an entry issued before all of its sources were broadcast");

    a_value: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> issue_a == tag_value(a_src[issue_dest_tag]) &&
                        issue_b == tag_value(b_src[issue_dest_tag]))
        else log_failure($sformatf("error at %0t: tag %0d issued operands %h %h", $time,
                                   $sampled(issue_dest_tag), $sampled(issue_a),
                                   $sampled(issue_b)));

    a_alu_full: assert property (@(posedge clock) disable iff (reset)
        alu_ready == (alu_count < rs_pkg::ALU_ENTRIES))
        else log_failure($sformatf("error at %0t: alu_ready wrong with %0d held", $time,
                                   $sampled(alu_count)));

    a_mult_full: assert property (@(posedge clock) disable iff (reset)
        mult_ready == (mult_count < rs_pkg::MULT_ENTRIES))
        else log_failure($sformatf("error at %0t: mult_ready wrong with %0d held", $time,
                                   $sampled(mult_count)));

    // Back-to-back ties hand the port over
    a_alternate: assert property (@(posedge clock) disable iff (reset)
        alu_req && mult_req ##1 alu_req && mult_req |-> issue_fu != $past(issue_fu))
        else log_failure("issue unit did not alternate under contention");

    a_squash: assert property (@(posedge clock) disable iff (reset)
        squash |-> !issue_valid ##1 alu_ready && mult_ready)
        else log_failure("squash did not block issue or leave both banks empty");

endmodule

// File: sim/rs_cluster_tb.sv
/* Testbench for the issue cluster. LFSR-driven dispatch and CDB traffic in five
   phases; the bound assertion module does the checking. */
module rs_cluster_tb;

    localparam int TW            = rs_pkg::TAG_WIDTH;
    localparam int PHASE1_CYCLES = 50;   // Reset plus ready dispatches
    localparam int PHASE2_CYCLES = 160;  // Waiting sources and delayed CDB
    localparam int PHASE3_CYCLES = 15;
    localparam int PHASE4_CYCLES = 15;
    localparam int PHASE5_CYCLES = 30;
    localparam int CYCLE_LIMIT   = PHASE1_CYCLES + PHASE2_CYCLES + PHASE3_CYCLES +
                                   PHASE4_CYCLES + PHASE5_CYCLES + 50;
    localparam logic [TW-1:0] HOLD_TAG   = 4'd15;  // Releases the full banks at once
    localparam logic [TW-1:0] SQUASH_TAG = 4'd14;  // Wakes the held entries just before the flush

    logic                          clock, reset, squash;
    logic                          dispatch_valid;
    rs_pkg::fu_t                   dispatch_fu;
    rs_pkg::alu_op_t               dispatch_alu_op;
    rs_pkg::mult_op_t              dispatch_mult_op;
    logic [TW-1:0]                 dispatch_dest_tag, src_a_tag, src_b_tag, cdb_tag;
    logic                          src_a_ready, src_b_ready, cdb_valid;
    logic [rs_pkg::DATA_WIDTH-1:0] src_a_value, src_b_value, cdb_value;
    logic                          alu_ready, mult_ready, issue_valid;
    rs_pkg::fu_t                   issue_fu;
    rs_pkg::alu_op_t               issue_alu_op;
    rs_pkg::mult_op_t              issue_mult_op;
    logic [TW-1:0]                 issue_dest_tag;
    logic [rs_pkg::DATA_WIDTH-1:0] issue_a, issue_b;

    logic [31:0]     lfsr = 32'he8cb;
    logic [15:0]     in_flight;       // Dest tags held by the cluster
    logic [TW-1:0]   next_tag;
    logic [TW-1:0]   bcast_tag [$];   // Pending CDB broadcasts in order
    int              bcast_due [$];
    int              cycle = 0;

    bind rs_cluster rs_cluster_props props (.*);

    rs_cluster UUT (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Verification failed");
            $fatal(1, "timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    always @(UUT.props.error_count) begin
        if (UUT.props.error_count != 0) begin
            $display("Verification failed");
            $fatal(1, "an assertion failed, run stopped");
        end
    end

    // Issue port is settled by mid-cycle
    always @(negedge clock) begin
        if (issue_valid) begin
            in_flight[issue_dest_tag] = 1'b0;
        end
    end

    // Galois step for x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};  // One step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [rs_pkg::DATA_WIDTH-1:0] value_of(input logic [TW-1:0] t);
        return {{(rs_pkg::DATA_WIDTH - TW){1'b0}}, t} * 32'h1111;
    endfunction

    // ALU ops cover five codes and multiplier ops one bit
    function automatic logic [2:0] pick_op(input rs_pkg::fu_t fu, input logic [2:0] bits);
        return (fu == rs_pkg::FU_ALU) ? 3'(bits % 5) : {2'b00, bits[0]};
    endfunction

    // Advance one cycle and drive inputs just after the edge
    task automatic next_cycle();
        @(posedge clock);
        #2;
        dispatch_valid = 1'b0;
        squash         = 1'b0;
        cdb_valid      = 1'b0;
        if (bcast_tag.size() != 0 && bcast_due[0] <= cycle) begin
            cdb_valid = 1'b1;
            cdb_tag   = bcast_tag.pop_front();
            cdb_value = value_of(cdb_tag);
            void'(bcast_due.pop_front());
        end
    endtask

    task automatic wait_space(input rs_pkg::fu_t fu);
        while (!((fu == rs_pkg::FU_ALU) ? alu_ready : mult_ready)) begin
            next_cycle();
        end
    endtask

    // One strobe. Waiting sources get a broadcast delay cycles later unless delay is below 1
    task automatic dispatch_op(input rs_pkg::fu_t fu, input logic [2:0] op,
                               input logic [TW-1:0] a, input logic [TW-1:0] b,
                               input logic a_rdy, input logic b_rdy, input int delay);
        while (in_flight[next_tag]) begin
            next_tag++;  // Keep dest tags unique
        end
        dispatch_valid      = 1'b1;
        dispatch_fu         = fu;
        dispatch_alu_op     = rs_pkg::alu_op_t'(op);
        dispatch_mult_op    = rs_pkg::mult_op_t'(op[0]);
        dispatch_dest_tag   = next_tag;
        src_a_tag           = a;
        src_a_ready         = a_rdy;
        src_a_value         = a_rdy ? value_of(a) : '0;
        src_b_tag           = b;
        src_b_ready         = b_rdy;
        src_b_value         = b_rdy ? value_of(b) : '0;
        in_flight[next_tag] = 1'b1;
        next_tag++;
        if (delay > 0 && !a_rdy) begin
            bcast_tag.push_back(a);
            bcast_due.push_back(cycle + delay);
        end
        if (delay > 0 && !b_rdy) begin
            bcast_tag.push_back(b);
            bcast_due.push_back(cycle + delay);
        end
        next_cycle();
    endtask

    task automatic random_dispatch(input logic allow_wait);
        logic [7:0]    r;
        rs_pkg::fu_t   fu;
        logic [2:0]    op;
        logic [TW-1:0] a;
        logic [TW-1:0] b;
        logic          a_rdy;
        logic          b_rdy;
        take_bits(1, r);
        fu = rs_pkg::fu_t'(r[0]);
        wait_space(fu);
        take_bits(3, r);
        op = pick_op(fu, r[2:0]);
        take_bits(TW, r);
        a = r[TW-1:0];
        take_bits(TW, r);
        b = r[TW-1:0];
        take_bits(3, r);
        a_rdy = !allow_wait || r[0];
        b_rdy = !allow_wait || r[1];
        if (!a_rdy && cdb_valid && r[2]) begin
            a = cdb_tag;  // Same-cycle CDB bypass
        end
        take_bits(3, r);
        dispatch_op(fu, op, a, b, a_rdy, b_rdy, 1 + r[2:0]);
    endtask

    // Both sources parked on one tag
    task automatic hold_dispatch(input rs_pkg::fu_t fu, input logic [TW-1:0] tag);
        logic [7:0] r;
        take_bits(3, r);
        wait_space(fu);
        dispatch_op(fu, pick_op(fu, r[2:0]), tag, tag, 1'b0, 1'b0, 0);
    endtask

    task automatic drain();
        while (in_flight != '0 || bcast_tag.size() != 0) begin
            next_cycle();
        end
    endtask

    initial begin
        reset             = 1'b1;
        squash            = 1'b0;
        dispatch_valid    = 1'b0;
        dispatch_fu       = rs_pkg::FU_ALU;
        dispatch_alu_op   = rs_pkg::ADD;
        dispatch_mult_op  = rs_pkg::MUL_LO;
        dispatch_dest_tag = '0;
        src_a_tag         = '0;
        src_a_ready       = 1'b0;
        src_a_value       = '0;
        src_b_tag         = '0;
        src_b_ready       = 1'b0;
        src_b_value       = '0;
        cdb_valid         = 1'b0;
        cdb_tag           = '0;
        cdb_value         = '0;
        in_flight         = '0;
        next_tag          = '0;
        repeat (3) @(posedge clock);
        #2 reset = 1'b0;
        next_cycle();
        repeat (12) random_dispatch(1'b0);  // Independent with operands given
        drain();
        repeat (12) random_dispatch(1'b1);  // Waiting sources
        drain();
        for (int i = 0; i < rs_pkg::ALU_ENTRIES; i++) begin
            hold_dispatch(rs_pkg::FU_ALU, HOLD_TAG);
        end
        for (int i = 0; i < rs_pkg::MULT_ENTRIES; i++) begin
            hold_dispatch(rs_pkg::FU_MULT, HOLD_TAG);
        end
        repeat (2) next_cycle();            // Both banks full
        bcast_tag.push_back(HOLD_TAG);      // Wakes all five for contested issue
        bcast_due.push_back(cycle);
        drain();
        for (int i = 0; i < rs_pkg::ALU_ENTRIES; i++) begin
            hold_dispatch(rs_pkg::FU_ALU, SQUASH_TAG);
        end
        for (int i = 0; i < rs_pkg::MULT_ENTRIES; i++) begin
            hold_dispatch(rs_pkg::FU_MULT, SQUASH_TAG);
        end
        bcast_tag.push_back(SQUASH_TAG);
        bcast_due.push_back(cycle);
        repeat (2) next_cycle();            // Held entries wake on the broadcast
        squash         = 1'b1;
        dispatch_valid = 1'b1;  // Dropped by the flush
        next_cycle();
        in_flight = '0;
        repeat (4) random_dispatch(1'b0);
        drain();
        repeat (2) next_cycle();
        if (UUT.props.error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
